/* tb.f */
heapPkg.sv
arrayTable.sv
elementStore.sv
heapControl.sv
heapTop.sv
heapTop_assert.sv
heapTb.sv

/* Makefile */
TOP = heapTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* heapTb.sv */
/*
  Testbench for the array heap: clock, reset, stimulus table with
  expected responses, compare task and cycle limit
*/
`timescale 1ns/1ps

module heapTb;
  import heapPkg::*;

  logic    clock;
  logic    reset;
  logic    valid;                         // Request strobe
  actionT  action;
  arrayIdT arrayId;
  indexT   index;
  dataT    in;
  logic    done;                          // Response strobe
  dataT    out;
  errorT   error;

  // ------------------------------
  // Stimulus table
  // ------------------------------
  actionT  rowAction [$];
  arrayIdT rowId [$];
  indexT   rowIndex [$];
  dataT    rowIn [$];
  dataT    rowOut [$];                    // Expected out
  errorT   rowError [$];                  // Expected error

  int currentRow;                         // Row under check
  int cycleCount;
  int cycleLimit;                         // Zero until the table is built

  heapTop UUT (
    .clock   (clock),
    .reset   (reset),
    .valid   (valid),
    .action  (action),
    .arrayId (arrayId),
    .index   (index),
    .in      (in),
    .done    (done),
    .out     (out),
    .error   (error)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;            // 8 ns period
  end

  task automatic addRow(input actionT a, input arrayIdT id, input indexT idx,
                        input dataT value, input dataT expOut, input errorT expError);
    rowAction.push_back(a);
    rowId.push_back(id);
    rowIndex.push_back(idx);
    rowIn.push_back(value);
    rowOut.push_back(expOut);
    rowError.push_back(expError);
  endtask

  task automatic checkValue(input string what, input int actual, input int expected);
    if (actual != expected) begin
      $display("ERROR at %0d ns: row %0d %s is %0h, expected %0h",
               $time, currentRow, what, actual, expected);
      $display("Simulation failed");
      $fatal(1, "Response mismatch");
    end
  endtask

  task automatic buildTable();
    // Fresh handles come out in order
    addRow(actAlloc,    3'd0, 2'd0, 12'h000, 12'h000, errNone);
    addRow(actAlloc,    3'd0, 2'd0, 12'h000, 12'h001, errNone);
    addRow(actAlloc,    3'd0, 2'd0, 12'h000, 12'h002, errNone);
    // Write past the end grows the size
    addRow(actWrite,    3'd0, 2'd2, 12'h5A5, 12'h5A5, errNone);
    addRow(actSize,     3'd0, 2'd0, 12'h000, 12'h003, errNone);
    addRow(actRead,     3'd0, 2'd2, 12'h000, 12'h5A5, errNone);
    addRow(actRead,     3'd0, 2'd3, 12'h000, 12'h000, errBounds);   // Index == size
    addRow(actRead,     3'd5, 2'd0, 12'h000, 12'h000, errNotAllocated);
    addRow(actWrite,    3'd6, 2'd0, 12'h001, 12'h000, errNotAllocated);
    addRow(actSize,     3'd7, 2'd0, 12'h000, 12'h000, errNotAllocated);
    // Stack behavior on handle 1
    addRow(actPush,     3'd1, 2'd0, 12'h111, 12'h111, errNone);
    addRow(actPush,     3'd1, 2'd0, 12'h222, 12'h222, errNone);
    addRow(actPush,     3'd1, 2'd0, 12'h333, 12'h333, errNone);
    addRow(actPush,     3'd1, 2'd0, 12'h444, 12'h444, errNone);
    addRow(actPush,     3'd1, 2'd0, 12'h555, 12'h000, errFull);     // Fifth push
    addRow(actSize,     3'd1, 2'd0, 12'h000, 12'h004, errNone);     // Still 4
    addRow(actRead,     3'd1, 2'd3, 12'h000, 12'h444, errNone);     // Last kept
    addRow(actPop,      3'd1, 2'd0, 12'h000, 12'h444, errNone);
    addRow(actPop,      3'd1, 2'd0, 12'h000, 12'h333, errNone);
    addRow(actPop,      3'd1, 2'd0, 12'h000, 12'h222, errNone);
    addRow(actPop,      3'd1, 2'd0, 12'h000, 12'h111, errNone);
    addRow(actPop,      3'd1, 2'd0, 12'h000, 12'h000, errEmpty);
    addRow(actSize,     3'd1, 2'd0, 12'h000, 12'h000, errNone);
    // Read-modify-write on handle 2
    addRow(actWrite,    3'd2, 2'd0, 12'hFF0, 12'hFF0, errNone);
    addRow(actAdd,      3'd2, 2'd0, 12'h020, 12'h010, errNone);     // Wraps past FFF
    addRow(actSubtract, 3'd2, 2'd0, 12'h030, 12'hFE0, errNone);     // Wraps below 0
    addRow(actOr,       3'd2, 2'd0, 12'h00F, 12'hFEF, errNone);
    addRow(actXor,      3'd2, 2'd0, 12'h0F0, 12'hF1F, errNone);
    addRow(actAnd,      3'd2, 2'd0, 12'h3C3, 12'h303, errNone);
    addRow(actRead,     3'd2, 2'd0, 12'h000, 12'h303, errNone);
    addRow(actAdd,      3'd2, 2'd1, 12'h001, 12'h000, errBounds);   // Size is 1
    // Freed handles come back last in first out
    addRow(actPush,     3'd1, 2'd0, 12'h666, 12'h666, errNone);     // Size 1 before free
    addRow(actFree,     3'd1, 2'd0, 12'h000, 12'h000, errNone);
    addRow(actFree,     3'd2, 2'd0, 12'h000, 12'h000, errNone);
    addRow(actFree,     3'd2, 2'd0, 12'h000, 12'h000, errNotAllocated); // Double free
    addRow(actRead,     3'd1, 2'd0, 12'h000, 12'h000, errNotAllocated);
    addRow(actAlloc,    3'd0, 2'd0, 12'h000, 12'h002, errNone);
    addRow(actSize,     3'd2, 2'd0, 12'h000, 12'h000, errNone);
    addRow(actAlloc,    3'd0, 2'd0, 12'h000, 12'h001, errNone);
    addRow(actSize,     3'd1, 2'd0, 12'h000, 12'h000, errNone);
    // Use up the rest
    addRow(actAlloc,    3'd0, 2'd0, 12'h000, 12'h003, errNone);
    addRow(actAlloc,    3'd0, 2'd0, 12'h000, 12'h004, errNone);
    addRow(actAlloc,    3'd0, 2'd0, 12'h000, 12'h005, errNone);
    addRow(actAlloc,    3'd0, 2'd0, 12'h000, 12'h006, errNone);
    addRow(actAlloc,    3'd0, 2'd0, 12'h000, 12'h007, errNone);
    addRow(actAlloc,    3'd0, 2'd0, 12'h000, 12'h000, errOutOfMemory);
    addRow(actFree,     3'd7, 2'd0, 12'h000, 12'h000, errNone);     // Failed alloc left 7 live
    addRow(actAlloc,    3'd0, 2'd0, 12'h000, 12'h007, errNone);
    addRow(actAlloc,    3'd0, 2'd0, 12'h000, 12'h000, errOutOfMemory);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    reset   = 1'b1;
    valid   = 1'b0;
    action  = actAlloc;
    arrayId = '0;
    index   = '0;
    in      = '0;
    buildTable();
    cycleLimit = rowAction.size() + 20;   // Rows plus reset and slack
    repeat (2) @(negedge clock);          // Two reset cycles
    reset = 1'b0;
    for (int i = 0; i < rowAction.size(); i++) begin
      currentRow = i;
      valid   = 1'b1;
      action  = rowAction[i];
      arrayId = rowId[i];
      index   = rowIndex[i];
      in      = rowIn[i];
      @(negedge clock);                   // Response registered by now
      valid = 1'b0;
      checkValue("done", int'(done), 1);
      checkValue("out", int'(out), int'(rowOut[i]));
      checkValue("error", int'(error), int'(rowError[i]));
    end
    @(negedge clock);
    checkValue("idle done", int'(done), 0);  // Strobe lasts one cycle
    $display("Simulation passed");
    $finish;
  end

  // ------------------------------
  // Cycle limit
  // ------------------------------
  initial begin
    cycleCount = 0;
    while (cycleLimit == 0 || cycleCount <= cycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout: test did not finish within %0d cycles", cycleLimit);
    $display("Simulation failed");
    $fatal(1, "Cycle limit reached");
  end

endmodule

/* heapTop_assert.sv */
/*
  Response protocol assertions bound to the heap top level
*/
`timescale 1ns/1ps

module heapTopAssert (
  input logic           clock,
  input logic           reset,
  input logic           valid,
  input logic           done,
  input heapPkg::dataT  out,
  input heapPkg::errorT error
);
  import heapPkg::*;

  // One response per request, one cycle later
  doneFollowsValid: assert property (@(posedge clock) disable iff (reset)
    done == $past(valid))
    else $error("done is not the previous cycle's valid");

  doneLowAfterReset: assert property (@(posedge clock)
    reset |=> !done)
    else $error("done high right after reset");

  // Failed requests return zero
  outZeroOnError: assert property (@(posedge clock) disable iff (reset)
    (error != errNone) |-> (out == '0))
    else $error("out not zero with an error response");

endmodule

bind heapTop heapTopAssert protocolChecks (
  .clock (clock),
  .reset (reset),
  .valid (valid),
  .done  (done),
  .out   (out),
  .error (error)
);

/* heapTop.sv */
/*
  Heap top level joining control, array table and element store
*/
`timescale 1ns/1ps

module heapTop (
  input  logic             clock,
  input  logic             reset,
  input  logic             valid,      // One-cycle request strobe
  input  heapPkg::actionT  action,
  input  heapPkg::arrayIdT arrayId,
  input  heapPkg::indexT   index,
  input  heapPkg::dataT    in,
  output logic             done,       // Response strobe
  output heapPkg::dataT    out,
  output heapPkg::errorT   error
);
  import heapPkg::*;

  // ----------------------------
  // Control to table and store
  // ----------------------------
  logic    allocate;
  logic    free;
  logic    sizeWrite;
  sizeT    newSize;
  indexT   elementIndex;
  logic    writeEnable;
  aluOpT   aluOp;
  dataT    operand;

  // Table and store back to control
  logic    allocated;
  sizeT    size;
  arrayIdT allocHandle;
  logic    allocAvailable;
  dataT    element;
  dataT    result;

  heapControl control (
    .clock          (clock),
    .reset          (reset),
    .valid          (valid),
    .action         (action),
    .arrayId        (arrayId),
    .index          (index),
    .in             (in),
    .allocated      (allocated),
    .size           (size),
    .allocHandle    (allocHandle),
    .allocAvailable (allocAvailable),
    .element        (element),
    .result         (result),
    .allocate       (allocate),
    .free           (free),
    .sizeWrite      (sizeWrite),
    .newSize        (newSize),
    .elementIndex   (elementIndex),
    .writeEnable    (writeEnable),
    .aluOp          (aluOp),
    .operand        (operand),
    .done           (done),
    .out            (out),
    .error          (error)
  );

  arrayTable table0 (
    .clock          (clock),
    .reset          (reset),
    .arrayId        (arrayId),       // Request handle addresses the table
    .allocate       (allocate),
    .free           (free),
    .sizeWrite      (sizeWrite),
    .newSize        (newSize),
    .allocated      (allocated),
    .size           (size),
    .allocHandle    (allocHandle),
    .allocAvailable (allocAvailable)
  );

  elementStore store (
    .clock          (clock),
    .arrayId        (arrayId),
    .elementIndex   (elementIndex),
    .writeEnable    (writeEnable),
    .aluOp          (aluOp),
    .operand        (operand),
    .element        (element),
    .result         (result)
  );

endmodule

/* heapControl.sv */
/*
  Heap control: action decode, access checks, table and store
  commands and the registered done, out and error response
*/
`timescale 1ns/1ps

module heapControl (
  input  logic             clock,
  input  logic             reset,
  input  logic             valid,          // Request strobe
  input  heapPkg::actionT  action,
  input  heapPkg::arrayIdT arrayId,
  input  heapPkg::indexT   index,
  input  heapPkg::dataT    in,
  input  logic             allocated,      // From table
  input  heapPkg::sizeT    size,
  input  heapPkg::arrayIdT allocHandle,
  input  logic             allocAvailable,
  input  heapPkg::dataT    element,        // From store
  input  heapPkg::dataT    result,
  output logic             allocate,       // To table
  output logic             free,
  output logic             sizeWrite,
  output heapPkg::sizeT    newSize,
  output heapPkg::indexT   elementIndex,   // To store
  output logic             writeEnable,
  output heapPkg::aluOpT   aluOp,
  output heapPkg::dataT    operand,
  output logic             done,           // Response one cycle later
  output heapPkg::dataT    out,
  output heapPkg::errorT   error
);
  import heapPkg::*;

  errorT check;                             // Error for this request
  errorT liveError;                         // Handle check only
  errorT boundsError;                       // Handle then bounds check
  dataT  respValue;                         // out when the request passes
  logic  issue;                             // Commands go out
  logic  inBounds;                          // index below size
  logic  wantAlloc;
  logic  wantFree;
  logic  wantSize;
  logic  wantWrite;
  sizeT  indexSize;                         // index widened to a size
  sizeT  sizeLess;                          // size - 1 for Pop

  // ----------------------------
  // Shared checks
  // ----------------------------
  assign indexSize = sizeT'(index);
  assign inBounds  = (indexSize < size);
  assign sizeLess  = size - sizeT'(1);

  assign liveError   = allocated ? errNone : errNotAllocated;
  assign boundsError = !allocated ? errNotAllocated :
                       !inBounds  ? errBounds       : errNone;

  assign operand = in;                      // Every store write uses in

  // ALU op follows the action directly
  always_comb begin
    case (action)
      actAdd:      aluOp = aluAdd;
      actSubtract: aluOp = aluSub;
      actOr:       aluOp = aluOr;
      actXor:      aluOp = aluXor;
      actAnd:      aluOp = aluAnd;
      default:     aluOp = aluLoad;         // Write and Push store in
    endcase
  end

  // ----------------------------
  // Decode
  // ----------------------------
  always_comb begin
    check        = errNone;
    respValue    = '0;
    wantAlloc    = 1'b0;
    wantFree     = 1'b0;
    wantSize     = 1'b0;
    wantWrite    = 1'b0;
    newSize      = size;
    elementIndex = index;
    case (action)
      actAlloc: begin
        check     = allocAvailable ? errNone : errOutOfMemory;
        wantAlloc = 1'b1;
        respValue = dataT'(allocHandle);    // Handle returned to caller
      end
      actFree: begin
        check    = liveError;               // Also catches double free
        wantFree = 1'b1;
      end
      actWrite: begin
        check     = liveError;
        wantWrite = 1'b1;
        respValue = in;
        if (!inBounds) begin
          wantSize = 1'b1;                  // Grow to cover index
          newSize  = indexSize + sizeT'(1);
        end
      end
      actRead: begin
        check     = boundsError;
        respValue = element;
      end
      actSize: begin
        check     = liveError;
        respValue = dataT'(size);
      end
      actPush: begin
        check = liveError;
        if (allocated && size == sizeT'(ArrayLength)) begin
          check = errFull;
        end
        elementIndex = size[IndexBits-1:0]; // Slot just past the end
        wantWrite    = 1'b1;
        wantSize     = 1'b1;
        newSize      = size + sizeT'(1);
        respValue    = in;
      end
      actPop: begin
        check = liveError;
        if (allocated && size == '0) begin
          check = errEmpty;
        end
        elementIndex = sizeLess[IndexBits-1:0];  // Last element
        wantSize     = 1'b1;
        newSize      = sizeLess;
        respValue    = element;
      end
      actAdd, actSubtract, actOr, actXor, actAnd: begin
        check     = boundsError;
        wantWrite = 1'b1;
        respValue = result;                 // New value after the op
      end
      default: ;                            // Unused codes do nothing
    endcase
  end

  // ----------------------------
  // Commands
  // ----------------------------
  assign issue       = valid && (check == errNone);  // Failures change nothing
  assign allocate    = issue && wantAlloc;
  assign free        = issue && wantFree;
  assign sizeWrite   = issue && wantSize;
  assign writeEnable = issue && wantWrite;

  // ----------------------------
  // Response
  // ----------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      done  <= 1'b0;
      out   <= '0;
      error <= errNone;
    end else begin
      done  <= valid;                       // Fixed one-cycle latency
      error <= valid ? check : errNone;
      out   <= issue ? respValue : '0;      // Zero on any error
    end
  end

endmodule

/* elementStore.sv */
/*
  Element store: ArrayCount by ArrayLength words with a
  read-modify-write ALU on the addressed element
*/
`timescale 1ns/1ps

module elementStore (
  input  logic             clock,
  input  heapPkg::arrayIdT arrayId,       // Array handle
  input  heapPkg::indexT   elementIndex,  // Element within the array
  input  logic             writeEnable,   // Store result this edge
  input  heapPkg::aluOpT   aluOp,         // How operand meets element
  input  heapPkg::dataT    operand,
  output heapPkg::dataT    element,       // Current contents
  output heapPkg::dataT    result         // Value that would be stored
);
  import heapPkg::*;

  dataT memory [ArrayCount][ArrayLength];  // One block per array

  // ----------------------------
  // Read side
  // ----------------------------
  assign element = memory[arrayId][elementIndex];  // Asynchronous read

  // ----------------------------
  // ALU
  // ----------------------------
  // Arithmetic wraps at DataBits
  always_comb begin
    case (aluOp)
      aluLoad: result = operand;          // Plain write
      aluAdd:  result = element + operand;
      aluSub:  result = element - operand;
      aluOr:   result = element | operand;
      aluXor:  result = element ^ operand;
      aluAnd:  result = element & operand;
      default: result = element;          // Unused codes keep the word
    endcase
  end

  // ----------------------------
  // Write back
  // ----------------------------
  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[arrayId][elementIndex] <= result;
    end
  end

endmodule

/* arrayTable.sv */
/*
  Array table: allocation flags, array sizes, fresh handle counter
  and the LIFO stack of freed handles
*/
`timescale 1ns/1ps

module arrayTable (
  input  logic             clock,
  input  logic             reset,
  input  heapPkg::arrayIdT arrayId,         // Addressed handle
  input  logic             allocate,        // Claim allocHandle
  input  logic             free,            // Release arrayId
  input  logic             sizeWrite,       // Load newSize for arrayId
  input  heapPkg::sizeT    newSize,
  output logic             allocated,       // arrayId is live
  output heapPkg::sizeT    size,            // Size of arrayId
  output heapPkg::arrayIdT allocHandle,     // Handle the next alloc gets
  output logic             allocAvailable   // Some handle is left
);
  import heapPkg::*;

  // Counts run from 0 to ArrayCount inclusive
  typedef logic [AddressBits:0] countT;

  logic [ArrayCount-1:0] allocFlags;        // One bit per array
  sizeT                  sizes [ArrayCount];
  arrayIdT               freeStack [ArrayCount];
  countT                 stackTop;          // Entries on freeStack
  countT                 freshCount;        // Handles never handed out
  countT                 stackBelow;        // Index of the top entry
  logic                  stackEmpty;

  // ----------------------------
  // Lookups
  // ----------------------------
  assign allocated  = allocFlags[arrayId];
  assign size       = sizes[arrayId];

  assign stackEmpty = (stackTop == '0);
  assign stackBelow = stackTop - countT'(1);

  // Reuse freed handles before fresh ones
  assign allocHandle = stackEmpty ? freshCount[AddressBits-1:0]
                                  : freeStack[stackBelow[AddressBits-1:0]];

  assign allocAvailable = !stackEmpty || (freshCount != countT'(ArrayCount));

  // ----------------------------
  // Control state
  // ----------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocFlags <= '0;                     // Nothing live
      stackTop   <= '0;                     // Stack empty
      freshCount <= '0;                     // Start from handle 0
    end else begin
      if (allocate) begin
        allocFlags[allocHandle] <= 1'b1;
        if (!stackEmpty) begin
          stackTop <= stackBelow;           // Pop reused handle
        end else begin
          freshCount <= freshCount + countT'(1);
        end
      end
      if (free) begin
        allocFlags[arrayId] <= 1'b0;
        stackTop            <= stackTop + countT'(1);
      end
    end
  end

  // ----------------------------
  // Sizes and freed handles
  // ----------------------------
  always_ff @(posedge clock) begin
    if (allocate) begin
      sizes[allocHandle] <= '0;             // New array starts empty
    end else if (sizeWrite) begin
      sizes[arrayId] <= newSize;
    end
  end

  // At most ArrayCount handles can be live so the push slot always fits
  always_ff @(posedge clock) begin
    if (free) begin
      freeStack[stackTop[AddressBits-1:0]] <= arrayId;
    end
  end

endmodule

/* heapPkg.sv */
/*
  Shared widths, width typedefs and the action, ALU operation and
  error encodings of the fixed-size array heap
*/
package heapPkg;

  // ----------------------------
  // Geometry
  // ----------------------------
  localparam int AddressBits = 3;                 // Handle width
  localparam int IndexBits   = 2;                 // Element index width
  localparam int DataBits    = 12;                // Element width

  localparam int ArrayCount  = 2 ** AddressBits;  // Arrays in the heap
  localparam int ArrayLength = 2 ** IndexBits;    // Elements per array

  // ----------------------------
  // Width types
  // ----------------------------
  typedef logic [AddressBits-1:0] arrayIdT;       // Array handle
  typedef logic [IndexBits-1:0]   indexT;         // Element index
  typedef logic [IndexBits:0]     sizeT;          // Size from 0 to ArrayLength
  typedef logic [DataBits-1:0]    dataT;          // Element or data word

  // ----------------------------
  // Encodings
  // ----------------------------
  typedef enum logic [3:0] {
    actAlloc,                                     // Take a free handle
    actFree,                                      // Return a handle
    actWrite,                                     // Store in at index
    actRead,                                      // Fetch element at index
    actSize,                                      // Current size
    actPush,                                      // Append at the end
    actPop,                                       // Remove from the end
    actAdd,                                       // Element plus in
    actSubtract,                                  // Element minus in
    actOr,
    actXor,
    actAnd
  } actionT;

  typedef enum logic [2:0] {
    aluLoad,                                      // Operand replaces element
    aluAdd,
    aluSub,
    aluOr,
    aluXor,
    aluAnd
  } aluOpT;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                              // Handle not live
    errBounds,                                    // Index not below size
    errFull,                                      // Push on full array
    errEmpty,                                     // Pop on empty array
    errOutOfMemory                                // No handle left
  } errorT;

endpackage
